/* core_pkg.sv */
package core_pkg;

    // data path and address width
    localparam int xlen = 32;

    // instruction id width, one id per fetch attempt
    localparam int id_w = 64;

    // read request to the instruction memory
    typedef struct packed {
        logic [xlen-1:0] addr;
    } mem_req_t;

    // write port, used to load a program while the core is in reset
    typedef struct packed {
        logic            we;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] data;
    } mem_wr_t;

    // fetched word on its way to decode
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
        logic [id_w-1:0] id;
    } fetch_out_t;

    // redirect request from decode back to fetch
    typedef struct packed {
        logic            hazard;
        logic [xlen-1:0] target;
    } redirect_t;

endpackage

/* isa_pkg.sv */
package isa_pkg;

    // major opcodes seen by decode
    typedef enum logic [6:0] {
        op_jal   = 7'b1101111,
        op_imm   = 7'b0010011,
        op_lui   = 7'b0110111,
        op_store = 7'b0100011,
        op_other = 7'b0000000
    } opcode_e;

    // register layout, also carries the I, U and S immediate bits
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // jal layout with the scattered offset fields
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, two views
    typedef union packed {
        r_fmt_t r_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    // decoded entry handed to the next stage
    typedef struct packed {
        logic [core_pkg::xlen-1:0] pc;
        logic [31:0]               id;
        logic [4:0]                rd;
        opcode_e                   kind;
        logic [core_pkg::xlen-1:0] imm;
        logic                      is_jump;
    } dec_inst_t;

endpackage

/* inst_mem.sv */
`timescale 1ns/1ps

module inst_mem #(
    parameter int mem_words   = 256,
    // valid range 1 to 4
    parameter int mem_latency = 2
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  core_pkg::mem_wr_t         mem_wr,
    input  logic                      mem_start,
    input  core_pkg::mem_req_t        mem_req,
    output logic                      mem_ready,
    output logic [core_pkg::xlen-1:0] mem_data,
    output logic                      mem_data_valid
);

    import core_pkg::*;

    localparam int aw = $clog2(mem_words);

    logic [xlen-1:0]        mem_array [mem_words];
    logic [mem_latency-1:0] vld_q;
    logic [xlen-1:0]        data_q [mem_latency];
    logic                   take;

    assign take = mem_start && mem_ready;

    // busy while a read sits in any stage but the last
    always_comb begin
        mem_ready = 1'b1;
        for (int i = 0; i < mem_latency - 1; i++) begin
            if (vld_q[i]) begin
                mem_ready = 1'b0;
            end
        end
    end

    // byte addresses, word granular storage
    always_ff @(posedge clk) begin
        if (mem_wr.we) begin
            mem_array[mem_wr.addr[aw+1:2]] <= mem_wr.data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= take;
            for (int i = 1; i < mem_latency; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            data_q[0] <= mem_array[mem_req.addr[aw+1:2]];
        end
        for (int i = 1; i < mem_latency; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    assign mem_data       = data_q[mem_latency-1];
    assign mem_data_valid = vld_q[mem_latency-1];

endmodule

/* fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
    input  logic                 clk,
    input  logic                 arst_n,

    output logic                 mem_start,
    output core_pkg::mem_req_t   mem_req,
    input  logic                 mem_ready,
    input  logic [31:0]          mem_data,
    input  logic                 mem_data_valid,

    output core_pkg::fetch_out_t fetch_out,
    input  logic                 stall,
    input  core_pkg::redirect_t  redirect
);

    import core_pkg::*;

    typedef enum logic [1:0] {
        wait_ready,
        wait_valid,
        fetched_wait_move
    } state_e;

    state_e          state_q;
    logic [xlen-1:0] pc_q;
    logic [id_w-1:0] id_q;
    // set when a redirect lands on a read already in flight
    logic            stale_q;

    logic [xlen-1:0] saved_pc_q;
    logic [xlen-1:0] saved_inst_q;
    logic [id_w-1:0] saved_id_q;

    logic            arrive;
    logic            start_c;
    logic [xlen-1:0] addr_c;

    // a word for the current pc is on the memory bus
    assign arrive = state_q == wait_valid && mem_data_valid && !stale_q;

    always_comb begin
        fetch_out.valid = !redirect.hazard && (arrive || state_q == fetched_wait_move);
        if (state_q == fetched_wait_move) begin
            fetch_out.pc   = saved_pc_q;
            fetch_out.inst = saved_inst_q;
            fetch_out.id   = saved_id_q;
        end else begin
            fetch_out.pc   = pc_q;
            fetch_out.inst = mem_data;
            fetch_out.id   = id_q;
        end
    end

    // request generation, never issued unless the memory can take it
    always_comb begin
        start_c = 1'b0;
        addr_c  = pc_q;
        if (redirect.hazard) begin
            start_c = 1'b1;
            addr_c  = redirect.target;
        end else begin
            case (state_q)
                wait_ready: begin
                    start_c = 1'b1;
                end
                wait_valid: begin
                    if (stale_q) begin
                        // old word drains, refetch the redirect target
                        start_c = mem_data_valid;
                    end else begin
                        start_c = mem_data_valid && !stall;
                        addr_c  = pc_q + 32'd4;
                    end
                end
                fetched_wait_move: begin
                    start_c = !stall;
                end
                default: begin
                    start_c = 1'b0;
                end
            endcase
        end
        mem_start    = start_c && mem_ready;
        mem_req.addr = addr_c;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= wait_ready;
            pc_q    <= '0;
            id_q    <= '0;
            stale_q <= 1'b0;
        end else if (redirect.hazard) begin
            pc_q <= redirect.target;
            id_q <= id_q + 1'b1;
            if (mem_ready) begin
                state_q <= wait_valid;
                stale_q <= 1'b0;
            end else if (state_q == wait_valid) begin
                // target request waits for the pending word
                stale_q <= 1'b1;
            end else begin
                state_q <= wait_ready;
            end
        end else begin
            case (state_q)
                wait_ready: begin
                    if (mem_ready) begin
                        state_q <= wait_valid;
                    end
                end
                wait_valid: begin
                    if (mem_data_valid && stale_q) begin
                        stale_q <= 1'b0;
                    end else if (arrive) begin
                        pc_q    <= pc_q + 32'd4;
                        id_q    <= id_q + 1'b1;
                        state_q <= stall ? fetched_wait_move :
                                   (mem_ready ? wait_valid : wait_ready);
                    end
                end
                fetched_wait_move: begin
                    if (!stall) begin
                        state_q <= mem_ready ? wait_valid : wait_ready;
                    end
                end
                default: begin
                    state_q <= wait_ready;
                end
            endcase
        end
    end

    // keep the word while decode is stalled
    always_ff @(posedge clk) begin
        if (!redirect.hazard && arrive && stall) begin
            saved_pc_q   <= pc_q;
            saved_inst_q <= mem_data;
            saved_id_q   <= id_q;
        end
    end

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                 clk,
    input  logic                 arst_n,

    input  core_pkg::fetch_out_t fetch_in,
    output logic                 stall,
    output core_pkg::redirect_t  redirect,

    input  logic                 out_stall,
    output logic                 dec_valid,
    output isa_pkg::dec_inst_t   dec_out
);

    import core_pkg::*;
    import isa_pkg::*;

    inst_u           word;
    opcode_e         kind;
    logic [xlen-1:0] imm;
    logic            accept;
    dec_inst_t       dec_next;

    logic            hazard_q;
    logic [xlen-1:0] target_q;

    assign word = fetch_in.inst;

    // held entry blocks the fetch stage only when it cannot leave
    assign stall = dec_valid && out_stall;

    // the cycle of a redirect discards whatever fetch shows
    assign accept = fetch_in.valid && !stall && !hazard_q;

    always_comb begin
        case (word.r_fmt.opcode)
            op_jal:   kind = op_jal;
            op_imm:   kind = op_imm;
            op_lui:   kind = op_lui;
            op_store: kind = op_store;
            default:  kind = op_other;
        endcase
    end

    always_comb begin
        case (kind)
            op_imm: begin
                imm = {{20{word.r_fmt.funct7[6]}}, word.r_fmt.funct7, word.r_fmt.rs2};
            end
            op_lui: begin
                imm = {word.r_fmt.funct7, word.r_fmt.rs2, word.r_fmt.rs1,
                       word.r_fmt.funct3, 12'b0};
            end
            op_store: begin
                imm = {{20{word.r_fmt.funct7[6]}}, word.r_fmt.funct7, word.r_fmt.rd};
            end
            op_jal: begin
                // offset bits reassembled from the J layout
                imm = {{11{word.j_fmt.imm20}}, word.j_fmt.imm20, word.j_fmt.imm19_12,
                       word.j_fmt.imm11, word.j_fmt.imm10_1, 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

    always_comb begin
        dec_next.pc      = fetch_in.pc;
        dec_next.id      = fetch_in.id[31:0];
        dec_next.rd      = word.r_fmt.rd;
        dec_next.kind    = kind;
        dec_next.imm     = imm;
        dec_next.is_jump = kind == op_jal;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
            hazard_q  <= 1'b0;
        end else begin
            hazard_q <= accept && dec_next.is_jump;
            if (accept) begin
                dec_valid <= 1'b1;
            end else if (!out_stall) begin
                dec_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec_out  <= dec_next;
            target_q <= fetch_in.pc + imm;
        end
    end

    assign redirect.hazard = hazard_q;
    assign redirect.target = target_q;

endmodule

/* fetch_top.sv */
`timescale 1ns/1ps

module fetch_top #(
    parameter int mem_words   = 256,
    parameter int mem_latency = 2
) (
    input  logic               clk,
    input  logic               arst_n,
    input  core_pkg::mem_wr_t  mem_wr,
    input  logic               out_stall,
    output logic               dec_valid,
    output isa_pkg::dec_inst_t dec_out
);

    import core_pkg::*;

    // memory bus
    logic            mem_start;
    mem_req_t        mem_req;
    logic            mem_ready;
    logic [xlen-1:0] mem_data;
    logic            mem_data_valid;

    // fetch to decode
    fetch_out_t      fetch_out;
    logic            stall;
    redirect_t       redirect;

    inst_mem #(
        .mem_words   (mem_words),
        .mem_latency (mem_latency)
    ) u_inst_mem (
        .clk            (clk),
        .arst_n         (arst_n),
        .mem_wr         (mem_wr),
        .mem_start      (mem_start),
        .mem_req        (mem_req),
        .mem_ready      (mem_ready),
        .mem_data       (mem_data),
        .mem_data_valid (mem_data_valid)
    );

    fetch_stage u_fetch_stage (
        .clk            (clk),
        .arst_n         (arst_n),
        .mem_start      (mem_start),
        .mem_req        (mem_req),
        .mem_ready      (mem_ready),
        .mem_data       (mem_data),
        .mem_data_valid (mem_data_valid),
        .fetch_out      (fetch_out),
        .stall          (stall),
        .redirect       (redirect)
    );

    decode_stage u_decode_stage (
        .clk       (clk),
        .arst_n    (arst_n),
        .fetch_in  (fetch_out),
        .stall     (stall),
        .redirect  (redirect),
        .out_stall (out_stall),
        .dec_valid (dec_valid),
        .dec_out   (dec_out)
    );

endmodule

/* fetch_top_assert.sv */
`timescale 1ns/1ps

module fetch_top_assert (
    input logic                 clk,
    input logic                 arst_n,
    input logic                 mem_start,
    input logic                 mem_ready,
    input core_pkg::fetch_out_t fetch_out,
    input logic                 stall,
    input core_pkg::redirect_t  redirect
);

    // one read at a time, the next request waits for the word
    one_read_in_flight: assert property (@(posedge clk) disable iff (!arst_n)
        mem_start |=> !mem_start || mem_data_valid_seen())
        else $error("second request issued while a read was in flight");

    // a word fetched before a redirect never reaches decode after it
    no_stale_after_hazard: assert property (@(posedge clk) disable iff (!arst_n)
        redirect.hazard |=> !fetch_out.valid || $past(mem_start))
        else $error("word from before a redirect shown to decode");

    // word shown to a stalled decode must not move
    hold_while_stalled: assert property (@(posedge clk) disable iff (!arst_n)
        stall && fetch_out.valid |=> !stall || $stable(fetch_out))
        else $error("fetch output changed while stalled");

    // memory ready comes back together with the returning word
    function automatic logic mem_data_valid_seen();
        return mem_ready;
    endfunction

endmodule

bind fetch_stage fetch_top_assert u_fetch_top_assert (
    .clk       (clk),
    .arst_n    (arst_n),
    .mem_start (mem_start),
    .mem_ready (mem_ready),
    .fetch_out (fetch_out),
    .stall     (stall),
    .redirect  (redirect)
);

/* tb_fetch_top.sv */
`timescale 1ns/1ps

module tb_fetch_top;

    import core_pkg::*;
    import isa_pkg::*;

    logic        clk;
    logic        arst_n;
    mem_wr_t     mem_wr;
    logic        out_stall;
    logic        dec_valid;
    dec_inst_t   dec_out;

    logic [31:0] prog [$];
    dec_inst_t   got [$];
    string       test_name;
    int          errors;
    int          checks;

    fetch_top #(
        .mem_words   (256),
        .mem_latency (2)
    ) u_fetch_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .mem_wr    (mem_wr),
        .out_stall (out_stall),
        .dec_valid (dec_valid),
        .dec_out   (dec_out)
    );

    always #4 clk = ~clk;

    // an entry leaves decode when valid and not stalled
    always @(posedge clk) begin
        if (arst_n && dec_valid && !out_stall) begin
            got.push_back(dec_out);
        end
    end

    // RV32I encodings
    function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [31:0] imm);
        return {imm[11:0], 5'd0, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] enc_sw(input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [31:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic check_eq(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("[ERROR] %s: %s", test_name, msg);
    endtask

    // program goes in while the core sits in reset
    task automatic load_and_reset();
        arst_n    = 1'b0;
        out_stall = 1'b0;
        got.delete();
        foreach (prog[i]) begin
            @(negedge clk);
            mem_wr = '{we: 1'b1, addr: 32'(i * 4), data: prog[i]};
        end
        @(negedge clk);
        mem_wr = '0;
        repeat (3) begin
            @(negedge clk);
            check_eq("dec_valid in reset", 32'd0, 32'(dec_valid));
        end
        arst_n = 1'b1;
    endtask

    task automatic wait_entries(input int n, input bit random_stall);
        int cycles;
        cycles = 0;
        while (got.size() < n && cycles < 400) begin
            @(negedge clk);
            out_stall = random_stall ? ($urandom % 3 == 0) : 1'b0;
            cycles++;
        end
        out_stall = 1'b0;
        if (got.size() < n) begin
            report_error($sformatf("timed out with %0d of %0d entries", got.size(), n));
        end
    endtask

    task automatic test_sequential();
        test_name = "sequential";
        prog.delete();
        for (int i = 0; i < 10; i++) begin
            prog.push_back(enc_addi(5'(i + 1), 32'(i * 3 - 7)));
        end
        load_and_reset();
        wait_entries(10, 1'b0);
        foreach (got[i]) begin
            check_eq("pc", 32'(i * 4), got[i].pc);
            check_eq("rd", 32'(i + 1), 32'(got[i].rd));
            check_eq("kind", 32'h13, 32'(got[i].kind));
            check_eq("imm", 32'(i * 3 - 7), got[i].imm);
            check_eq("is_jump", 32'd0, 32'(got[i].is_jump));
        end
    endtask

    // same program as before, only the reset window matters
    task automatic test_reset_state();
        test_name = "reset_state";
        load_and_reset();
        repeat (2) begin
            @(negedge clk);
            check_eq("dec_valid after reset", 32'd0, 32'(dec_valid));
        end
        wait_entries(1, 1'b0);
    endtask

    task automatic test_immediates();
        logic [31:0] exp_pc [8];
        logic [31:0] exp_imm [8];
        test_name = "immediates";
        prog.delete();
        prog.push_back(enc_addi(5'd1, -5));
        prog.push_back(enc_addi(5'd2, 2047));
        prog.push_back(enc_lui(5'd3, 20'hfffff));
        prog.push_back(enc_lui(5'd4, 20'h12345));
        prog.push_back(enc_sw(5'd6, 5'd5, -100));
        prog.push_back(enc_sw(5'd8, 5'd7, 44));
        prog.push_back(enc_jal(5'd1, 8));
        prog.push_back(enc_addi(5'd9, 1));
        prog.push_back(enc_jal(5'd0, -32));
        exp_pc  = '{0, 4, 8, 12, 16, 20, 24, 32};
        exp_imm = '{32'hffff_fffb, 32'h0000_07ff, 32'hffff_f000, 32'h1234_5000,
                    32'hffff_ff9c, 32'h0000_002c, 32'h0000_0008, 32'hffff_ffe0};
        load_and_reset();
        wait_entries(8, 1'b0);
        foreach (got[i]) begin
            check_eq("pc", exp_pc[i], got[i].pc);
            check_eq("imm", exp_imm[i], got[i].imm);
            check_eq("is_jump", 32'(i >= 6), 32'(got[i].is_jump));
        end
    endtask

    task automatic test_jal_redirect();
        logic [31:0] exp_pc [5];
        test_name = "jal_redirect";
        prog.delete();
        for (int i = 0; i < 12; i++) begin
            prog.push_back(enc_addi(5'(i + 1), 32'(i)));
        end
        prog[2] = enc_jal(5'd1, 32);
        exp_pc  = '{0, 4, 8, 40, 44};
        load_and_reset();
        wait_entries(5, 1'b0);
        foreach (got[i]) begin
            check_eq("pc", exp_pc[i], got[i].pc);
            if (got[i].pc >= 32'd12 && got[i].pc <= 32'd36) begin
                report_error($sformatf("skipped word at pc %0d left decode", got[i].pc));
            end
        end
        if (got.size() >= 4 && got[3].id <= got[2].id + 32'd1) begin
            report_error("target id is not past the jal id plus one");
        end
    endtask

    task automatic test_backpressure();
        test_name = "backpressure";
        prog.delete();
        for (int i = 0; i < 20; i++) begin
            prog.push_back(enc_addi(5'(i % 31 + 1), 32'(i * 5 - 50)));
        end
        load_and_reset();
        wait_entries(20, 1'b1);
        foreach (got[i]) begin
            check_eq("pc", 32'(i * 4), got[i].pc);
            check_eq("rd", 32'(i % 31 + 1), 32'(got[i].rd));
            check_eq("imm", 32'(i * 5 - 50), got[i].imm);
            if (i > 0 && got[i].id <= got[i-1].id) begin
                report_error($sformatf("id did not increase at entry %0d", i));
            end
        end
    endtask

    task automatic test_stall_redirect();
        logic [31:0] exp_pc [4];
        int          cycles;
        int          jumps;
        test_name = "stall_redirect";
        prog.delete();
        for (int i = 0; i < 8; i++) begin
            prog.push_back(enc_addi(5'(i + 1), 32'(i)));
        end
        prog[1] = enc_jal(5'd1, 16);
        exp_pc  = '{0, 4, 20, 24};
        load_and_reset();
        cycles = 0;
        // freeze decode as soon as the jal is its output
        while (!(dec_valid && dec_out.is_jump) && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        if (!(dec_valid && dec_out.is_jump)) begin
            report_error("jal never reached the decode output");
        end
        out_stall = 1'b1;
        repeat (8) begin
            @(negedge clk);
            check_eq("held valid", 32'd1, 32'(dec_valid));
            check_eq("held pc", 32'd4, dec_out.pc);
        end
        wait_entries(4, 1'b0);
        jumps = 0;
        foreach (got[i]) begin
            check_eq("pc", exp_pc[i], got[i].pc);
            if (got[i].is_jump) begin
                jumps++;
            end
        end
        check_eq("jal entries", 32'd1, 32'(jumps));
    endtask

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        out_stall = 1'b0;
        mem_wr    = '0;
        errors    = 0;
        checks    = 0;
        void'($urandom(91332));
        test_sequential();
        test_reset_state();
        test_immediates();
        test_jal_redirect();
        test_backpressure();
        test_stall_redirect();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
core_pkg.sv
isa_pkg.sv
inst_mem.sv
fetch_stage.sv
decode_stage.sv
fetch_top.sv
fetch_top_assert.sv
tb_fetch_top.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_fetch_top -f sources.f

# keep the output even when the simulation exits with an error
out=$(./obj_dir/Vtb_fetch_top 2>&1) || true
echo "$out"

if grep -qx "Result: PASSED" <<< "$out"; then
    exit 0
fi
exit 1
